// File: list.f
src/axi_mux_cfg_pkg.sv
src/axi_id_pkg.sv
src/w_order_fifo.sv
src/aw_rr_arbiter.sv
src/aw_w_route.sv
src/aw_spill_reg.sv
src/b_resp_router.sv
src/axi_wmux_top.sv
verif/tb_axi_wmux.sv

// File: src/aw_rr_arbiter.sv
// Round-robin AW arbiter over all slave ports
// The granted port stays fixed while its request waits downstream
// The granted ID is extended with the port index
`timescale 1ns/1ps
`default_nettype none

module aw_rr_arbiter
  import axi_mux_cfg_pkg::*, axi_id_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic    [NUM_PORTS-1:0]  slv_aw_valid_i,
  input  slv_id_t [NUM_PORTS-1:0]  slv_aw_id_i,
  input  addr_t   [NUM_PORTS-1:0]  slv_aw_addr_i,
  input  len_t    [NUM_PORTS-1:0]  slv_aw_len_i,
  output logic    [NUM_PORTS-1:0]  slv_aw_ready_o,
  output logic                     arb_aw_valid_o,
  input  logic                     arb_aw_ready_i,
  output mst_id_u                  arb_aw_id_o,
  output addr_t                    arb_aw_addr_o,
  output len_t                     arb_aw_len_o
);

  port_idx_t rr_ptr_q;     // Last granted port
  logic      lock_q;       // Request pending downstream
  port_idx_t lock_idx_q;
  port_idx_t rr_idx;       // Next requester after the pointer
  port_idx_t gnt_idx;
  logic      aw_stall;

  //----------------------------------------------------------------------
  // Round-robin search
  //----------------------------------------------------------------------
  always_comb begin
    port_idx_t cand;
    rr_idx = rr_ptr_q;
    // Walk from the far end so the nearest requester wins
    for (int i = NUM_PORTS; i >= 1; i--) begin
      cand = port_idx_t'((rr_ptr_q + i) % NUM_PORTS);
      if (slv_aw_valid_i[cand]) begin
        rr_idx = cand;
      end
    end
  end

  assign gnt_idx        = lock_q ? lock_idx_q : rr_idx;
  assign arb_aw_valid_o = slv_aw_valid_i[gnt_idx];
  assign aw_stall       = arb_aw_valid_o & ~arb_aw_ready_i;

  always_comb begin
    slv_aw_ready_o          = '0;
    slv_aw_ready_o[gnt_idx] = arb_aw_ready_i;
    arb_aw_id_o.fld.idx     = gnt_idx;               // Prepend the port index
    arb_aw_id_o.fld.id      = slv_aw_id_i[gnt_idx];
    arb_aw_addr_o           = slv_aw_addr_i[gnt_idx];
    arb_aw_len_o            = slv_aw_len_i[gnt_idx];
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_ptr_q   <= port_idx_t'(NUM_PORTS - 1);   // Port 0 goes first
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      lock_q <= aw_stall;
      if (aw_stall) begin
        lock_idx_q <= gnt_idx;
      end
      if (arb_aw_valid_o && arb_aw_ready_i) begin
        rr_ptr_q <= gnt_idx;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/aw_spill_reg.sv
// Two-slot spill register on the master AW channel
// Breaks every combinational path between both sides
// ready_o comes from the fill state only
`timescale 1ns/1ps
`default_nettype none

module aw_spill_reg
  import axi_id_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  logic    valid_i,
  output logic    ready_o,
  input  mst_id_u id_i,
  input  addr_t   addr_i,
  input  len_t    len_i,
  output logic    valid_o,
  input  logic    ready_i,
  output mst_id_u id_o,
  output addr_t   addr_o,
  output len_t    len_o
);

  logic    a_full_q, b_full_q;
  logic    a_fill, a_drain;
  logic    b_fill, b_drain;
  mst_id_u a_id_q,   b_id_q;
  addr_t   a_addr_q, b_addr_q;
  len_t    a_len_q,  b_len_q;

  // Slot A takes new entries and slot B holds the older one on a stall
  assign a_fill  = valid_i & ready_o;
  assign a_drain = a_full_q & ~b_full_q;
  assign b_fill  = a_drain & ~ready_i;
  assign b_drain = b_full_q & ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill || a_drain) begin
        a_full_q <= a_fill;
      end
      if (b_fill || b_drain) begin
        b_full_q <= b_fill;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_id_q   <= id_i;
      a_addr_q <= addr_i;
      a_len_q  <= len_i;
    end
    if (b_fill) begin
      b_id_q   <= a_id_q;
      b_addr_q <= a_addr_q;
      b_len_q  <= a_len_q;
    end
  end

  assign ready_o = ~a_full_q | ~b_full_q;
  assign valid_o = a_full_q | b_full_q;
  assign id_o    = b_full_q ? b_id_q   : a_id_q;     // Older entry first
  assign addr_o  = b_full_q ? b_addr_q : a_addr_q;
  assign len_o   = b_full_q ? b_len_q  : a_len_q;

endmodule

`default_nettype wire

// File: src/aw_w_route.sv
// AW handoff and W steering
// Each accepted AW pushes its port index into the order FIFO once
// W beats pass combinationally from the port at the FIFO head
`timescale 1ns/1ps
`default_nettype none

module aw_w_route
  import axi_mux_cfg_pkg::*, axi_id_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // Arbitrated AW
  input  logic                   arb_aw_valid_i,
  output logic                   arb_aw_ready_o,
  input  mst_id_u                arb_aw_id_i,
  input  addr_t                  arb_aw_addr_i,
  input  len_t                   arb_aw_len_i,
  // Toward the AW spill register
  output logic                   route_aw_valid_o,
  input  logic                   route_aw_ready_i,
  output mst_id_u                route_aw_id_o,
  output addr_t                  route_aw_addr_o,
  output len_t                   route_aw_len_o,
  // W channels
  input  logic  [NUM_PORTS-1:0]  slv_w_valid_i,
  input  data_t [NUM_PORTS-1:0]  slv_w_data_i,
  input  logic  [NUM_PORTS-1:0]  slv_w_last_i,
  output logic  [NUM_PORTS-1:0]  slv_w_ready_o,
  output logic                   mst_w_valid_o,
  input  logic                   mst_w_ready_i,
  output data_t                  mst_w_data_o,
  output logic                   mst_w_last_o
);

  logic      lock_d, lock_q;  // Decision already pushed
  logic      fifo_push, fifo_pop;
  logic      fifo_full, fifo_empty;
  port_idx_t w_sel;

  //----------------------------------------------------------------------
  // AW control
  //----------------------------------------------------------------------
  always_comb begin
    lock_d           = lock_q;
    fifo_push        = 1'b0;
    route_aw_valid_o = 1'b0;
    arb_aw_ready_o   = 1'b0;
    if (lock_q) begin
      route_aw_valid_o = 1'b1;          // Hold valid without a second push
      if (route_aw_ready_i) begin
        arb_aw_ready_o = 1'b1;
        lock_d         = 1'b0;
      end
    end else if (arb_aw_valid_i && !fifo_full) begin
      route_aw_valid_o = 1'b1;
      fifo_push        = 1'b1;
      if (route_aw_ready_i) begin
        arb_aw_ready_o = 1'b1;
      end else begin
        lock_d = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lock_q <= 1'b0;
    end else begin
      lock_q <= lock_d;
    end
  end

  assign route_aw_id_o   = arb_aw_id_i;
  assign route_aw_addr_o = arb_aw_addr_i;
  assign route_aw_len_o  = arb_aw_len_i;

  w_order_fifo i_w_fifo (
    .clk_i      ( clk_i               ),
    .rst_n_i    ( rst_n_i             ),
    .push_i     ( fifo_push           ),
    .push_idx_i ( arb_aw_id_i.fld.idx ),
    .pop_i      ( fifo_pop            ),
    .full_o     ( fifo_full           ),
    .empty_o    ( fifo_empty          ),
    .head_idx_o ( w_sel               )
  );

  //----------------------------------------------------------------------
  // W steering
  //----------------------------------------------------------------------
  assign mst_w_data_o  = slv_w_data_i[w_sel];
  assign mst_w_last_o  = slv_w_last_i[w_sel];
  assign mst_w_valid_o = ~fifo_empty & slv_w_valid_i[w_sel];
  assign fifo_pop      = mst_w_valid_o & mst_w_ready_i & mst_w_last_o;  // Burst done

  always_comb begin
    slv_w_ready_o        = '0;
    slv_w_ready_o[w_sel] = ~fifo_empty & mst_w_ready_i;
  end

endmodule

`default_nettype wire

// File: src/axi_id_pkg.sv
// Channel field types of the multiplexer
// Master IDs carry the slave port index in their upper bits
// Compile after axi_mux_cfg_pkg
`default_nettype none

package axi_id_pkg;

  import axi_mux_cfg_pkg::*;

  typedef logic [IDX_W-1:0]    port_idx_t;
  typedef logic [SLV_ID_W-1:0] slv_id_t;
  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [DATA_W-1:0]   data_t;
  typedef logic [LEN_W-1:0]    len_t;
  typedef logic [1:0]          resp_t;   // OKAY, EXOKAY, SLVERR, DECERR

  // Master ID seen either as a bus word or as its two fields
  typedef union packed {
    logic [MST_ID_W-1:0] word;
    struct packed {
      port_idx_t idx;   // Slave port that issued the burst
      slv_id_t   id;    // ID as seen on that slave port
    } fld;
  } mst_id_u;

endpackage

`default_nettype wire

// File: src/axi_mux_cfg_pkg.sv
// Size settings of the write-only AXI multiplexer
// NUM_PORTS must be a power of two so that a port index fills IDX_W bits
// MAX_W_TRANS limits the bursts whose W beats are still pending
`default_nettype none

package axi_mux_cfg_pkg;

  //----------------------------------------------------------------------
  // Port count and channel widths
  //----------------------------------------------------------------------
  localparam int unsigned NUM_PORTS = 4;
  localparam int unsigned IDX_W     = $clog2(NUM_PORTS);  // Port index bits
  localparam int unsigned SLV_ID_W  = 4;
  localparam int unsigned MST_ID_W  = SLV_ID_W + IDX_W;   // ID extended by the port index
  localparam int unsigned ADDR_W    = 32;
  localparam int unsigned DATA_W    = 32;
  localparam int unsigned LEN_W     = 8;

  //----------------------------------------------------------------------
  // Write order FIFO
  //----------------------------------------------------------------------
  localparam int unsigned MAX_W_TRANS = 8;
  localparam int unsigned FIFO_PTR_W  = $clog2(MAX_W_TRANS);
  localparam int unsigned FIFO_CNT_W  = $clog2(MAX_W_TRANS + 1);  // Counts 0 to full

endpackage

`default_nettype wire

// File: src/axi_wmux_top.sv
// Write-only AXI multiplexer, NUM_PORTS slave ports onto one master port
// Master IDs are IDX_W bits wider than slave IDs
// At most MAX_W_TRANS bursts may wait for their W beats
`timescale 1ns/1ps
`default_nettype none

module axi_wmux_top
  import axi_mux_cfg_pkg::*, axi_id_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // Slave ports
  input  logic    [NUM_PORTS-1:0]  slv_aw_valid_i,
  input  slv_id_t [NUM_PORTS-1:0]  slv_aw_id_i,
  input  addr_t   [NUM_PORTS-1:0]  slv_aw_addr_i,
  input  len_t    [NUM_PORTS-1:0]  slv_aw_len_i,
  output logic    [NUM_PORTS-1:0]  slv_aw_ready_o,
  input  logic    [NUM_PORTS-1:0]  slv_w_valid_i,
  input  data_t   [NUM_PORTS-1:0]  slv_w_data_i,
  input  logic    [NUM_PORTS-1:0]  slv_w_last_i,
  output logic    [NUM_PORTS-1:0]  slv_w_ready_o,
  output logic    [NUM_PORTS-1:0]  slv_b_valid_o,
  output slv_id_t [NUM_PORTS-1:0]  slv_b_id_o,
  output resp_t   [NUM_PORTS-1:0]  slv_b_resp_o,
  input  logic    [NUM_PORTS-1:0]  slv_b_ready_i,
  // Master port
  output logic                     mst_aw_valid_o,
  input  logic                     mst_aw_ready_i,
  output mst_id_u                  mst_aw_id_o,
  output addr_t                    mst_aw_addr_o,
  output len_t                     mst_aw_len_o,
  output logic                     mst_w_valid_o,
  input  logic                     mst_w_ready_i,
  output data_t                    mst_w_data_o,
  output logic                     mst_w_last_o,
  input  logic                     mst_b_valid_i,
  output logic                     mst_b_ready_o,
  input  mst_id_u                  mst_b_id_i,
  input  resp_t                    mst_b_resp_i
);

  logic    arb_aw_valid, arb_aw_ready;
  mst_id_u arb_aw_id;
  addr_t   arb_aw_addr;
  len_t    arb_aw_len;

  logic    route_aw_valid, route_aw_ready;
  mst_id_u route_aw_id;
  addr_t   route_aw_addr;
  len_t    route_aw_len;

  aw_rr_arbiter i_aw_arb (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .slv_aw_valid_i ( slv_aw_valid_i ),
    .slv_aw_id_i    ( slv_aw_id_i    ),
    .slv_aw_addr_i  ( slv_aw_addr_i  ),
    .slv_aw_len_i   ( slv_aw_len_i   ),
    .slv_aw_ready_o ( slv_aw_ready_o ),
    .arb_aw_valid_o ( arb_aw_valid   ),
    .arb_aw_ready_i ( arb_aw_ready   ),
    .arb_aw_id_o    ( arb_aw_id      ),
    .arb_aw_addr_o  ( arb_aw_addr    ),
    .arb_aw_len_o   ( arb_aw_len     )
  );

  aw_w_route i_route (
    .clk_i            ( clk_i          ),
    .rst_n_i          ( rst_n_i        ),
    .arb_aw_valid_i   ( arb_aw_valid   ),
    .arb_aw_ready_o   ( arb_aw_ready   ),
    .arb_aw_id_i      ( arb_aw_id      ),
    .arb_aw_addr_i    ( arb_aw_addr    ),
    .arb_aw_len_i     ( arb_aw_len     ),
    .route_aw_valid_o ( route_aw_valid ),
    .route_aw_ready_i ( route_aw_ready ),
    .route_aw_id_o    ( route_aw_id    ),
    .route_aw_addr_o  ( route_aw_addr  ),
    .route_aw_len_o   ( route_aw_len   ),
    .slv_w_valid_i    ( slv_w_valid_i  ),
    .slv_w_data_i     ( slv_w_data_i   ),
    .slv_w_last_i     ( slv_w_last_i   ),
    .slv_w_ready_o    ( slv_w_ready_o  ),
    .mst_w_valid_o    ( mst_w_valid_o  ),
    .mst_w_ready_i    ( mst_w_ready_i  ),
    .mst_w_data_o     ( mst_w_data_o   ),
    .mst_w_last_o     ( mst_w_last_o   )
  );

  aw_spill_reg i_aw_spill (
    .clk_i   ( clk_i          ),
    .rst_n_i ( rst_n_i        ),
    .valid_i ( route_aw_valid ),
    .ready_o ( route_aw_ready ),
    .id_i    ( route_aw_id    ),
    .addr_i  ( route_aw_addr  ),
    .len_i   ( route_aw_len   ),
    .valid_o ( mst_aw_valid_o ),
    .ready_i ( mst_aw_ready_i ),
    .id_o    ( mst_aw_id_o    ),
    .addr_o  ( mst_aw_addr_o  ),
    .len_o   ( mst_aw_len_o   )
  );

  b_resp_router i_b_router (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .mst_b_valid_i ( mst_b_valid_i ),
    .mst_b_ready_o ( mst_b_ready_o ),
    .mst_b_id_i    ( mst_b_id_i    ),
    .mst_b_resp_i  ( mst_b_resp_i  ),
    .slv_b_valid_o ( slv_b_valid_o ),
    .slv_b_ready_i ( slv_b_ready_i ),
    .slv_b_id_o    ( slv_b_id_o    ),
    .slv_b_resp_o  ( slv_b_resp_o  )
  );

endmodule

`default_nettype wire

// File: src/b_resp_router.sv
// B response buffer and router back to the slave ports
// Two entries in ping-pong slots, so mst_b_ready_o is a register output
// The upper ID bits select the port and are removed from the returned ID
`timescale 1ns/1ps
`default_nettype none

module b_resp_router
  import axi_mux_cfg_pkg::*, axi_id_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     mst_b_valid_i,
  output logic                     mst_b_ready_o,
  input  mst_id_u                  mst_b_id_i,
  input  resp_t                    mst_b_resp_i,
  output logic    [NUM_PORTS-1:0]  slv_b_valid_o,
  input  logic    [NUM_PORTS-1:0]  slv_b_ready_i,
  output slv_id_t [NUM_PORTS-1:0]  slv_b_id_o,
  output resp_t   [NUM_PORTS-1:0]  slv_b_resp_o
);

  logic    [1:0] slot_vld_q;
  mst_id_u [1:0] slot_id_q;
  resp_t   [1:0] slot_resp_q;
  logic          wr_sel_q, rd_sel_q;
  logic          b_push, b_pop;
  logic          head_vld;
  mst_id_u       head_id;

  assign mst_b_ready_o = ~slot_vld_q[wr_sel_q];
  assign b_push        = mst_b_valid_i & mst_b_ready_o;

  assign head_vld = slot_vld_q[rd_sel_q];
  assign head_id  = slot_id_q[rd_sel_q];
  assign b_pop    = head_vld & slv_b_ready_i[head_id.fld.idx];  // Ready of the owner only

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      slot_vld_q <= '0;
      wr_sel_q   <= 1'b0;
      rd_sel_q   <= 1'b0;
    end else begin
      // Push and pop never hit the same slot
      if (b_push) begin
        slot_vld_q[wr_sel_q] <= 1'b1;
        wr_sel_q             <= ~wr_sel_q;
      end
      if (b_pop) begin
        slot_vld_q[rd_sel_q] <= 1'b0;
        rd_sel_q             <= ~rd_sel_q;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (b_push) begin
      slot_id_q[wr_sel_q]   <= mst_b_id_i;
      slot_resp_q[wr_sel_q] <= mst_b_resp_i;
    end
  end

  //----------------------------------------------------------------------
  // Fan out to the slave ports
  //----------------------------------------------------------------------
  always_comb begin
    slv_b_valid_o = '0;
    slv_b_valid_o[head_id.fld.idx] = head_vld;
  end

  assign slv_b_id_o   = {NUM_PORTS{head_id.fld.id}};        // Stripped ID on every port
  assign slv_b_resp_o = {NUM_PORTS{slot_resp_q[rd_sel_q]}};

endmodule

`default_nettype wire

// File: src/w_order_fifo.sv
// Order FIFO of slave port indices for accepted write bursts
// No fall-through, so a pushed entry shows at the head one cycle later
// Push while full and pop while empty are ignored
`timescale 1ns/1ps
`default_nettype none

module w_order_fifo
  import axi_mux_cfg_pkg::*, axi_id_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      push_i,
  input  port_idx_t push_idx_i,
  input  logic      pop_i,
  output logic      full_o,
  output logic      empty_o,
  output port_idx_t head_idx_o
);

  port_idx_t               mem_q [MAX_W_TRANS];
  logic [FIFO_PTR_W-1:0]   wr_ptr_q;
  logic [FIFO_PTR_W-1:0]   rd_ptr_q;
  logic [FIFO_CNT_W-1:0]   count_q;
  logic                    do_push;
  logic                    do_pop;

  assign full_o     = (count_q == FIFO_CNT_W'(MAX_W_TRANS));
  assign empty_o    = (count_q == '0);
  assign head_idx_o = mem_q[rd_ptr_q];

  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  // Pointers and fill level
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == FIFO_PTR_W'(MAX_W_TRANS - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == FIFO_PTR_W'(MAX_W_TRANS - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_idx_i;
    end
  end

endmodule

`default_nettype wire

// File: verif/tb_axi_wmux.sv
// Self-checking testbench for the write-only AXI multiplexer
// Four slave port models issue AWs and then their W beats, one master model
// accepts AW and W and returns B responses in random order
// Beat data is {port, slave ID, beat, burst number}, 8 bits each
// Random stimulus comes from a Galois LFSR with a fixed seed
`timescale 1ns/1ps
`default_nettype none

module tb_axi_wmux
  import axi_mux_cfg_pkg::*, axi_id_pkg::*;
();

  logic                    clk_i;
  logic                    rst_n_i;
  logic    [NUM_PORTS-1:0] slv_aw_valid_i;
  slv_id_t [NUM_PORTS-1:0] slv_aw_id_i;
  addr_t   [NUM_PORTS-1:0] slv_aw_addr_i;
  len_t    [NUM_PORTS-1:0] slv_aw_len_i;
  logic    [NUM_PORTS-1:0] slv_aw_ready_o;
  logic    [NUM_PORTS-1:0] slv_w_valid_i;
  data_t   [NUM_PORTS-1:0] slv_w_data_i;
  logic    [NUM_PORTS-1:0] slv_w_last_i;
  logic    [NUM_PORTS-1:0] slv_w_ready_o;
  logic    [NUM_PORTS-1:0] slv_b_valid_o;
  slv_id_t [NUM_PORTS-1:0] slv_b_id_o;
  resp_t   [NUM_PORTS-1:0] slv_b_resp_o;
  logic    [NUM_PORTS-1:0] slv_b_ready_i;
  logic                    mst_aw_valid_o;
  logic                    mst_aw_ready_i;
  mst_id_u                 mst_aw_id_o;
  addr_t                   mst_aw_addr_o;
  len_t                    mst_aw_len_o;
  logic                    mst_w_valid_o;
  logic                    mst_w_ready_i;
  data_t                   mst_w_data_o;
  logic                    mst_w_last_o;
  logic                    mst_b_valid_i;
  logic                    mst_b_ready_o;
  mst_id_u                 mst_b_id_i;
  resp_t                   mst_b_resp_i;

  // Stimulus state
  logic [31:0]         lfsr_q;
  logic                gap_en, aw_stall_en, w_stall_en, b_stall_en, w_hold;
  int unsigned         aw_left [NUM_PORTS];   // AWs still to issue
  int unsigned         aw_seq  [NUM_PORTS];
  int unsigned         aw_acc  [NUM_PORTS];   // AWs accepted so far
  int unsigned         w_seq   [NUM_PORTS];
  int unsigned         w_beat  [NUM_PORTS];
  slv_id_t             burst_id  [NUM_PORTS][256];
  len_t                burst_len [NUM_PORTS][256];
  logic [MST_ID_W-1:0] b_pend_q [$];          // Finished bursts awaiting B
  int                  total_bursts;

  // Reference state
  logic [MST_ID_W+ADDR_W+LEN_W-1:0] exp_aw_q [$];
  logic [31:0]                      exp_w_q [$];  // {port, id, len, burst number}
  logic [MST_ID_W+1:0]              exp_b_q [$];  // {port, id, resp}
  int unsigned          chk_seq [NUM_PORTS];
  int                   chk_beat;
  int                   slv_aw_cnt, mst_aw_cnt, w_done_cnt, open_cnt;
  int                   fair_cnt [NUM_PORTS][NUM_PORTS];

  axi_wmux_top u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  //--------------------------------------------------------------------
  // Helpers
  //--------------------------------------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r      = {r[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
    return r;
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input string test, input logic [63:0] exp,
                                 input logic [63:0] act);
    stop_on_error($sformatf("[FAIL] %s: expected 'h%0h, actual 'h%0h", test, exp, act));
  endtask

  task automatic start_traffic(input int unsigned bursts, input logic gaps);
    for (int p = 0; p < NUM_PORTS; p++) begin
      aw_left[p] = bursts;
    end
    total_bursts += NUM_PORTS * bursts;
    gap_en      = gaps;
    aw_stall_en = 1'b1;
    w_stall_en  = 1'b1;
    b_stall_en  = 1'b1;
  endtask

  function automatic logic traffic_idle();
    logic idle;
    idle = (slv_aw_valid_i == '0) && (open_cnt == 0);
    for (int p = 0; p < NUM_PORTS; p++) begin
      idle &= (aw_left[p] == 0);
    end
    return idle;
  endfunction

  task automatic wait_idle(input string phase);
    int cycles;
    cycles = 0;
    while (!traffic_idle()) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > 5000) begin
        stop_on_error($sformatf("Timeout: %s traffic did not drain", phase));
      end
    end
  endtask

  //--------------------------------------------------------------------
  // Slave port models and master model
  //--------------------------------------------------------------------
  always @(posedge clk_i) begin
    logic        aw_hs, w_hs, b_hs;
    int unsigned s;
    int          pick;
    if (rst_n_i) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        aw_hs = slv_aw_valid_i[p] & slv_aw_ready_o[p];
        if (aw_hs) begin
          aw_acc[p]++;
        end
        if ((!slv_aw_valid_i[p] || aw_hs) && aw_left[p] != 0 &&
            (!gap_en || rand_bits(2) != 0)) begin
          s = aw_seq[p] % 256;
          burst_id[p][s]    = slv_id_t'(rand_bits(SLV_ID_W));
          burst_len[p][s]   = len_t'(rand_bits(2));      // 1 to 4 beats
          slv_aw_valid_i[p] <= 1'b1;
          slv_aw_id_i[p]    <= burst_id[p][s];
          slv_aw_addr_i[p]  <= rand_bits(ADDR_W);
          slv_aw_len_i[p]   <= burst_len[p][s];
          aw_seq[p]++;
          aw_left[p]--;
        end else if (aw_hs) begin
          slv_aw_valid_i[p] <= 1'b0;
        end

        // W beats follow the port's own AW order
        w_hs = slv_w_valid_i[p] & slv_w_ready_o[p];
        if (w_hs && slv_w_last_i[p]) begin
          w_seq[p]++;
          w_beat[p] = 0;
        end else if (w_hs) begin
          w_beat[p]++;
        end
        if ((!slv_w_valid_i[p] || w_hs) && w_seq[p] < aw_acc[p] &&
            (!gap_en || rand_bits(1) != 0)) begin
          s = w_seq[p] % 256;
          slv_w_valid_i[p] <= 1'b1;
          slv_w_data_i[p]  <= {8'(p), 8'(burst_id[p][s]), 8'(w_beat[p]), 8'(w_seq[p])};
          slv_w_last_i[p]  <= (w_beat[p] == burst_len[p][s]);
        end else if (w_hs) begin
          slv_w_valid_i[p] <= 1'b0;
        end
        slv_b_ready_i[p] <= b_stall_en ? (rand_bits(1) != 0) : 1'b1;
      end

      mst_aw_ready_i <= aw_stall_en ? (rand_bits(1) != 0) : 1'b1;
      mst_w_ready_i  <= w_hold ? 1'b0 : (w_stall_en ? (rand_bits(1) != 0) : 1'b1);
      if (mst_w_valid_o && mst_w_ready_i && mst_w_last_o) begin
        b_pend_q.push_back({mst_w_data_o[24 +: IDX_W], mst_w_data_o[16 +: SLV_ID_W]});
      end
      b_hs = mst_b_valid_i & mst_b_ready_o;
      if ((!mst_b_valid_i || b_hs) && b_pend_q.size() != 0 &&
          (!gap_en || rand_bits(1) != 0)) begin
        pick = int'(rand_bits(4)) % b_pend_q.size();    // Random response order
        mst_b_valid_i   <= 1'b1;
        mst_b_id_i.word <= b_pend_q[pick];
        mst_b_resp_i    <= resp_t'(rand_bits(2));
        b_pend_q.delete(pick);
      end else if (b_hs) begin
        mst_b_valid_i <= 1'b0;
      end
    end
  end

  //--------------------------------------------------------------------
  // Checks
  //--------------------------------------------------------------------
  always @(posedge clk_i) begin
    logic [MST_ID_W+ADDR_W+LEN_W-1:0] aw_exp;
    logic [31:0]                      w_rec;
    data_t                            w_data_exp;
    logic                             w_last_exp;
    logic [MST_ID_W+1:0]              b_exp;
    if (rst_n_i) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (slv_aw_valid_i[p] && slv_aw_ready_o[p]) begin
          exp_aw_q.push_back({port_idx_t'(p), slv_aw_id_i[p], slv_aw_addr_i[p],
                              slv_aw_len_i[p]});
          exp_w_q.push_back({8'(p), 8'(slv_aw_id_i[p]), slv_aw_len_i[p], 8'(chk_seq[p])});
          chk_seq[p]++;
          slv_aw_cnt++;
          open_cnt++;
          // Grants to other ports while p was waiting
          for (int q = 0; q < NUM_PORTS; q++) begin
            assert (fair_cnt[p][q] <= 1)
              else report_mismatch("rr_fairness", 1, fair_cnt[p][q]);
            fair_cnt[p][q] = 0;
            if (q != p && slv_aw_valid_i[q]) begin
              fair_cnt[q][p]++;                 // Only ports that are requesting
            end
          end
        end
      end

      if (mst_aw_valid_o && mst_aw_ready_i) begin
        assert (exp_aw_q.size() != 0)
          else stop_on_error("Master AW handshake without a matching slave AW");
        aw_exp = exp_aw_q.pop_front();
        assert ({mst_aw_id_o.word, mst_aw_addr_o, mst_aw_len_o} == aw_exp)
          else report_mismatch("aw_id_extension", aw_exp,
                               {mst_aw_id_o.word, mst_aw_addr_o, mst_aw_len_o});
        mst_aw_cnt++;
      end

      if (mst_w_valid_o && mst_w_ready_i) begin
        assert (exp_w_q.size() != 0)
          else stop_on_error("Master W beat without an accepted AW");
        w_rec      = exp_w_q[0];
        w_data_exp = {w_rec[31:16], 8'(chk_beat), w_rec[7:0]};
        w_last_exp = (chk_beat == int'(w_rec[15:8]));
        assert (mst_w_data_o == w_data_exp)
          else report_mismatch("w_order_data", w_data_exp, mst_w_data_o);
        assert (mst_w_last_o == w_last_exp)
          else report_mismatch("w_last", w_last_exp, mst_w_last_o);
        if (mst_w_last_o) begin
          void'(exp_w_q.pop_front());
          chk_beat = 0;
          w_done_cnt++;
        end else begin
          chk_beat++;
        end
      end

      assert ($countones(slv_b_valid_o) <= 1)
        else stop_on_error("B valid raised at more than one slave port");
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (slv_b_valid_o[p]) begin
          assert (exp_b_q.size() != 0)
            else stop_on_error("Slave B valid without a master B response");
          b_exp = exp_b_q[0];
          assert ({port_idx_t'(p), slv_b_id_o[p], slv_b_resp_o[p]} == b_exp)
            else report_mismatch("b_routing", b_exp,
                                 {port_idx_t'(p), slv_b_id_o[p], slv_b_resp_o[p]});
          if (slv_b_ready_i[p]) begin
            void'(exp_b_q.pop_front());
            open_cnt--;
          end
        end
      end
      if (mst_b_valid_i && mst_b_ready_o) begin
        exp_b_q.push_back({mst_b_id_i.word, mst_b_resp_i});
      end

      assert (mst_aw_cnt - w_done_cnt <= int'(MAX_W_TRANS))
        else report_mismatch("w_backpressure_limit", MAX_W_TRANS, mst_aw_cnt - w_done_cnt);
      assert (slv_aw_cnt - w_done_cnt <= int'(MAX_W_TRANS))
        else report_mismatch("w_fifo_limit", MAX_W_TRANS, slv_aw_cnt - w_done_cnt);
    end
  end

  //--------------------------------------------------------------------
  // Test sequence
  //--------------------------------------------------------------------
  initial begin
    int cycles;
    lfsr_q         = 32'ha902;
    rst_n_i        = 1'b0;
    slv_aw_valid_i = '0;
    slv_aw_id_i    = '0;
    slv_aw_addr_i  = '0;
    slv_aw_len_i   = '0;
    slv_w_valid_i  = '0;
    slv_w_data_i   = '0;
    slv_w_last_i   = '0;
    slv_b_ready_i  = '0;
    mst_aw_ready_i = 1'b0;
    mst_w_ready_i  = 1'b0;
    mst_b_valid_i  = 1'b0;
    mst_b_id_i     = '0;
    mst_b_resp_i   = '0;
    gap_en         = 1'b0;
    aw_stall_en    = 1'b0;
    w_stall_en     = 1'b0;
    b_stall_en     = 1'b0;
    w_hold         = 1'b0;
    total_bursts   = 0;

    @(posedge clk_i);
    @(negedge clk_i);
    // Every flop has taken reset by the first falling edge
    assert (slv_aw_ready_o == '0 && slv_w_ready_o == '0 && slv_b_valid_o == '0)
      else stop_on_error("Slave port valid or ready output active during reset");
    assert (!mst_aw_valid_o && !mst_w_valid_o && mst_b_ready_o)
      else stop_on_error("Master port outputs not idle during reset");
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);

    start_traffic(6, 1'b1);                     // Random gaps and stalls
    wait_idle("random");
    start_traffic(8, 1'b0);                     // All ports request back to back
    wait_idle("round-robin");

    // Hold master W until the order FIFO is full
    w_hold = 1'b1;
    start_traffic(4, 1'b0);
    cycles = 0;
    while (slv_aw_cnt - w_done_cnt < int'(MAX_W_TRANS)) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > 2000) begin
        stop_on_error("Timeout: order FIFO never filled while master W was held");
      end
    end
    repeat (20) @(negedge clk_i);
    w_hold = 1'b0;
    wait_idle("W back-pressure");

    if (exp_aw_q.size() == 0 && exp_w_q.size() == 0 && exp_b_q.size() == 0 &&
        mst_aw_cnt == slv_aw_cnt && slv_aw_cnt == total_bursts) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      stop_on_error("AW, W or B records left unmatched at the end of the run");
    end
  end

endmodule

`default_nettype wire
